// ==== common/trap_config.svh ====
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

`define XLEN            32
`define IM_ADDR_LEN     32  // instruction address.
`define DM_ADDR_LEN     32  // data address.
`define IM_DATA_LEN     32

////////////////////////////////////////////////////////////
// apb byte offsets of the machine trap registers
////////////////////////////////////////////////////////////

`define CSR_MTVEC       8'h00
`define CSR_MEPC        8'h04
`define CSR_MCAUSE      8'h08
`define CSR_MTVAL       8'h0c
`define CSR_MSCRATCH    8'h10

`endif

// ==== common/trap_pkg.sv ====
`default_nettype none

`include "trap_config.svh"

package trap_pkg;

    // privilege levels, as encoded in mstatus.
    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_S = 2'd1,
        PRV_H = 2'd2,
        PRV_M = 2'd3
    } priv_t;

    // synchronous exception codes for mcause.
    typedef enum logic [`XLEN-1:0] {
        exc_inst_misaligned  = `XLEN'd0,
        exc_inst_access      = `XLEN'd1,
        exc_illegal_inst     = `XLEN'd2,
        exc_breakpoint       = `XLEN'd3,
        exc_load_misaligned  = `XLEN'd4,
        exc_load_access      = `XLEN'd5,
        exc_store_misaligned = `XLEN'd6,
        exc_store_access     = `XLEN'd7,
        exc_ecall_u          = `XLEN'd8,
        exc_ecall_s          = `XLEN'd9,
        exc_ecall_m          = `XLEN'd11,
        exc_inst_page        = `XLEN'd12,
        exc_load_page        = `XLEN'd13,
        exc_store_page       = `XLEN'd15
    } exc_cause_t;

    // kind of fetch redirect in flight.
    typedef enum logic [1:0] {
        idle      = 2'd0,
        trap_jump = 2'd1,
        ret_jump  = 2'd2
    } redir_state_t;

    // fault report gathered from fetch, execute and writeback.
    typedef struct packed {
        logic                    inst_valid;
        logic [`IM_DATA_LEN-1:0] inst;
        logic [`IM_ADDR_LEN-1:0] exe_pc;
        logic [`IM_ADDR_LEN-1:0] wb_pc;
        logic [`DM_ADDR_LEN-1:0] ldst_badaddr;
        logic [`IM_ADDR_LEN-1:0] inst_badaddr;
        priv_t                   prv_cur;
        priv_t                   prv_req;
        logic                    satp_upd;
        logic                    tvm;
        logic                    tsr;
        logic                    sret;
        logic                    ecall;
        logic                    ebreak;
        logic                    tlb_flush_req;
        logic                    ill_inst;
        logic [`IM_ADDR_LEN-1:0] inst_misaligned_epc;
        logic                    inst_misaligned;
        logic                    inst_pg_fault;
        logic                    inst_xes_fault;
        logic                    load_misaligned;
        logic                    load_pg_fault;
        logic                    load_xes_fault;
        logic                    store_misaligned;
        logic                    store_pg_fault;
        logic                    store_xes_fault;
    } fault_req_t;

    typedef struct packed {
        logic                    valid;
        exc_cause_t              cause;
        logic [`IM_ADDR_LEN-1:0] epc;
        logic [`XLEN-1:0]        tval;
    } trap_rec_t;

    typedef struct packed {
        logic             psel;
        logic             penable;
        logic             pwrite;
        logic [7:0]       paddr;
        logic [`XLEN-1:0] pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

// ==== tpu/tpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module tpu
    import trap_pkg::*;
(
    input  fault_req_t fault,
    output trap_rec_t  trap
);

////////////////////////////////////////////////////////////
// per-flag trap conditions
////////////////////////////////////////////////////////////

logic ill_hit;
logic ecall_u_hit;
logic ecall_s_hit;
logic ecall_h_hit;
logic ecall_m_hit;
logic inst_brk_hit;
logic ldst_brk_hit;

logic if_hit;
logic exe_hit;
logic wb_hit;

logic [`XLEN-1:0] wb_code;
logic [`XLEN-1:0] if_code;
logic [`XLEN-1:0] exe_code;

// no trigger module, so both address breakpoints stay off.
assign inst_brk_hit = 1'b0;
assign ldst_brk_hit = 1'b0;

assign ill_hit = fault.ill_inst ||
                 (fault.prv_cur < fault.prv_req) ||
                 ((fault.satp_upd || fault.tlb_flush_req) && fault.tvm &&
                  (fault.prv_cur < PRV_M)) ||
                 (fault.sret && fault.tsr && (fault.prv_cur < PRV_M));

assign ecall_u_hit = fault.ecall && (fault.prv_cur == PRV_U);
assign ecall_s_hit = fault.ecall && (fault.prv_cur == PRV_S);
assign ecall_h_hit = fault.ecall && (fault.prv_cur == PRV_H); // traps, code stays 0.
assign ecall_m_hit = fault.ecall && (fault.prv_cur == PRV_M);

////////////////////////////////////////////////////////////
// stage classes
////////////////////////////////////////////////////////////

assign if_hit  = fault.inst_misaligned | fault.inst_xes_fault |
                 fault.inst_pg_fault | inst_brk_hit;

assign exe_hit = ill_hit | fault.ebreak |
                 ecall_u_hit | ecall_s_hit | ecall_h_hit | ecall_m_hit;

assign wb_hit  = fault.load_misaligned | fault.store_misaligned |
                 fault.load_xes_fault | fault.store_xes_fault |
                 fault.load_pg_fault | fault.store_pg_fault | ldst_brk_hit;

// codes within a class are merged, not prioritized.
always_comb begin
    wb_code = '0;
    if (fault.store_misaligned) wb_code |= exc_store_misaligned;
    if (fault.load_misaligned)  wb_code |= exc_load_misaligned;
    if (fault.store_pg_fault)   wb_code |= exc_store_page;
    if (fault.load_pg_fault)    wb_code |= exc_load_page;
    if (fault.store_xes_fault)  wb_code |= exc_store_access;
    if (fault.load_xes_fault)   wb_code |= exc_load_access;
    if (ldst_brk_hit)           wb_code |= exc_breakpoint;
end

always_comb begin
    if_code = '0;
    if (inst_brk_hit)          if_code |= exc_breakpoint;
    if (fault.inst_pg_fault)   if_code |= exc_inst_page;
    if (fault.inst_xes_fault)  if_code |= exc_inst_access;
    if (fault.inst_misaligned) if_code |= exc_inst_misaligned;
end

always_comb begin
    exe_code = '0;
    if (ill_hit)      exe_code |= exc_illegal_inst;
    if (ecall_u_hit)  exe_code |= exc_ecall_u;
    if (ecall_s_hit)  exe_code |= exc_ecall_s;
    if (ecall_m_hit)  exe_code |= exc_ecall_m;
    if (fault.ebreak) exe_code |= exc_breakpoint;
end

////////////////////////////////////////////////////////////
// trap record
////////////////////////////////////////////////////////////

always_comb begin
    // writeback is never gated by inst_valid.
    trap.valid = (fault.inst_valid && (if_hit || exe_hit)) || wb_hit;

    if (wb_hit)
        trap.cause = exc_cause_t'(wb_code);
    else if (if_hit)
        trap.cause = exc_cause_t'(if_code);
    else if (exe_hit)
        trap.cause = exc_cause_t'(exe_code);
    else
        trap.cause = exc_cause_t'('0);

    if (wb_hit)
        trap.epc = fault.wb_pc;
    else if (fault.inst_misaligned)
        trap.epc = fault.inst_misaligned_epc;
    else
        trap.epc = fault.exe_pc;

    if (wb_hit)
        trap.tval = fault.ldst_badaddr;
    else if (fault.inst_misaligned)
        trap.tval = fault.exe_pc;
    else if (if_hit)
        trap.tval = fault.inst_badaddr;
    else if (ill_hit)
        trap.tval = fault.inst;  // faulting encoding.
    else
        trap.tval = '0;
end

endmodule

`default_nettype wire

// ==== trap_csr/trap_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module trap_csr
    import trap_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  trap_rec_t        trap,
    input  apb_req_t         apb,
    output logic [`XLEN-1:0] prdata,
    output logic             pready,
    output logic             pslverr,
    output logic [`XLEN-1:0] mtvec_base,
    output logic [`XLEN-1:0] mepc_q
);

logic [`XLEN-1:0] mtvec_q;
logic [`XLEN-1:0] mcause_q;
logic [`XLEN-1:0] mtval_q;
logic [`XLEN-1:0] mscratch_q;

logic             apb_access;
logic             apb_wr;
logic             apb_rd;
logic             addr_hit;
logic [`XLEN-1:0] rd_mux;

logic wr_mtvec;
logic wr_mepc;
logic wr_mcause;
logic wr_mtval;
logic wr_mscratch;

////////////////////////////////////////////////////////////
// apb decode
////////////////////////////////////////////////////////////

assign apb_access = apb.psel && apb.penable;
assign apb_wr     = apb_access && apb.pwrite;
assign apb_rd     = apb_access && !apb.pwrite;

always_comb begin
    addr_hit = 1'b1;
    rd_mux   = '0;
    case (apb.paddr)
        `CSR_MTVEC:    rd_mux = mtvec_q;
        `CSR_MEPC:     rd_mux = mepc_q;
        `CSR_MCAUSE:   rd_mux = mcause_q;
        `CSR_MTVAL:    rd_mux = mtval_q;
        `CSR_MSCRATCH: rd_mux = mscratch_q;
        default:       addr_hit = 1'b0;
    endcase
end

assign wr_mtvec    = apb_wr && (apb.paddr == `CSR_MTVEC);
assign wr_mepc     = apb_wr && (apb.paddr == `CSR_MEPC);
assign wr_mcause   = apb_wr && (apb.paddr == `CSR_MCAUSE);
assign wr_mtval    = apb_wr && (apb.paddr == `CSR_MTVAL);
assign wr_mscratch = apb_wr && (apb.paddr == `CSR_MSCRATCH);

assign pready  = 1'b1;                   // zero wait states.
assign pslverr = apb_access && !addr_hit;
assign prdata  = apb_rd ? rd_mux : '0;   // unmapped reads zero.

////////////////////////////////////////////////////////////
// register state
////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (rst) begin
        mtvec_q    <= '0;
        mscratch_q <= '0;
    end else begin
        if (wr_mtvec)
            mtvec_q <= apb.pwdata;
        if (wr_mscratch)
            mscratch_q <= apb.pwdata;
    end
end

// a trap in the same cycle overrides software.
always_ff @(posedge clk) begin
    if (rst) begin
        mepc_q   <= '0;
        mcause_q <= '0;
        mtval_q  <= '0;
    end else if (trap.valid) begin
        mepc_q   <= `XLEN'(trap.epc);
        mcause_q <= trap.cause;
        mtval_q  <= trap.tval;
    end else begin
        if (wr_mepc)
            mepc_q <= {apb.pwdata[`XLEN-1:1], 1'b0}; // ialign, bit 0 always clear.
        if (wr_mcause)
            mcause_q <= apb.pwdata;
        if (wr_mtval)
            mtval_q <= apb.pwdata;
    end
end

// direct mode only, mode bits stay readable but are not part of the base.
assign mtvec_base = {mtvec_q[`XLEN-1:2], 2'b00};

endmodule

`default_nettype wire

// ==== verilog/trap_redirect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module trap_redirect
    import trap_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  trap_rec_t               trap,
    input  logic                    mret,
    input  logic [`XLEN-1:0]        mtvec_base,
    input  logic [`XLEN-1:0]        mepc_q,
    output logic                    redirect_valid,
    output logic [`IM_ADDR_LEN-1:0] redirect_pc
);

redir_state_t state_q;
redir_state_t state_d;

logic [`IM_ADDR_LEN-1:0] pc_q;

// trap has priority over mret.
always_comb begin
    if (trap.valid)
        state_d = trap_jump;
    else if (mret)
        state_d = ret_jump;
    else
        state_d = idle;
end

always_ff @(posedge clk) begin
    if (rst) begin
        state_q <= idle;
        pc_q    <= '0;
    end else begin
        state_q <= state_d;
        case (state_d)
            trap_jump: pc_q <= mtvec_base[`IM_ADDR_LEN-1:0];
            ret_jump:  pc_q <= mepc_q[`IM_ADDR_LEN-1:0];
            default:   pc_q <= pc_q;  // hold last target.
        endcase
    end
end

assign redirect_valid = (state_q != idle);
assign redirect_pc    = pc_q;

endmodule

`default_nettype wire

// ==== verilog/trap_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module trap_top
    import trap_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  fault_req_t              fault,
    input  logic                    mret,
    input  apb_req_t                apb,
    output logic [`XLEN-1:0]        prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    trap_taken,
    output logic                    redirect_valid,
    output logic [`IM_ADDR_LEN-1:0] redirect_pc
);

trap_rec_t        trap;
logic [`XLEN-1:0] mtvec_base;
logic [`XLEN-1:0] mepc_q;

////////////////////////////////////////////////////////////
// producer, buffer, consumer
////////////////////////////////////////////////////////////

tpu u_tpu (
    .fault (fault),
    .trap  (trap)
);

trap_csr u_trap_csr (
    .clk        (clk),
    .rst        (rst),
    .trap       (trap),
    .apb        (apb),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .mtvec_base (mtvec_base),
    .mepc_q     (mepc_q)
);

trap_redirect u_trap_redirect (
    .clk            (clk),
    .rst            (rst),
    .trap           (trap),
    .mret           (mret),
    .mtvec_base     (mtvec_base),
    .mepc_q         (mepc_q),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
);

assign trap_taken = trap.valid;  // same cycle as the fault.

endmodule

`default_nettype wire

// ==== tests/trap_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_clk_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;  // free running.
end

endmodule

`default_nettype wire

// ==== tests/trap_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module trap_props
    import trap_pkg::*;
(
    input logic                    clk,
    input logic                    rst,
    input fault_req_t              fault,
    input logic                    mret,
    input apb_req_t                apb,
    input logic                    pready,
    input logic                    pslverr,
    input trap_rec_t               trap,
    input logic                    trap_taken,
    input logic                    redirect_valid,
    input logic [`IM_ADDR_LEN-1:0] redirect_pc,
    input logic [`XLEN-1:0]        mtvec_base,
    input logic [`XLEN-1:0]        mepc_q
);

int unsigned fail_cnt = 0;

logic             ill;
logic             wb_cls;
logic             if_cls;
logic             exe_cls;
logic             exp_valid;
logic [`XLEN-1:0] exp_cause;
logic [`XLEN-1:0] exp_epc;
logic [`XLEN-1:0] exp_tval;

////////////////////////////////////////////////////////////
// expected record for one flag per class
////////////////////////////////////////////////////////////

always_comb begin
    ill = fault.ill_inst || (fault.prv_cur < fault.prv_req) ||
          ((fault.satp_upd || fault.tlb_flush_req) && fault.tvm && fault.prv_cur != PRV_M) ||
          (fault.sret && fault.tsr && fault.prv_cur != PRV_M);
    wb_cls = fault.load_misaligned || fault.load_xes_fault || fault.load_pg_fault ||
             fault.store_misaligned || fault.store_xes_fault || fault.store_pg_fault;
    if_cls  = fault.inst_misaligned || fault.inst_xes_fault || fault.inst_pg_fault;
    exe_cls = ill || fault.ebreak || fault.ecall;
    exp_valid = wb_cls || (fault.inst_valid && (if_cls || exe_cls));

    exp_cause = 32'd0;
    if (wb_cls) begin
        if (fault.load_misaligned)       exp_cause = 32'd4;
        else if (fault.load_xes_fault)   exp_cause = 32'd5;
        else if (fault.store_misaligned) exp_cause = 32'd6;
        else if (fault.store_xes_fault)  exp_cause = 32'd7;
        else if (fault.load_pg_fault)    exp_cause = 32'd13;
        else                             exp_cause = 32'd15;
    end else if (if_cls) begin
        if (fault.inst_xes_fault)     exp_cause = 32'd1;
        else if (fault.inst_pg_fault) exp_cause = 32'd12;
    end else if (ill) begin
        exp_cause = 32'd2;
    end else if (fault.ebreak) begin
        exp_cause = 32'd3;
    end else if (fault.ecall) begin
        case (fault.prv_cur)
            PRV_U:   exp_cause = 32'd8;
            PRV_S:   exp_cause = 32'd9;
            PRV_M:   exp_cause = 32'd11;
            default: exp_cause = 32'd0;  // hypervisor ecall keeps code 0.
        endcase
    end

    exp_epc = wb_cls ? fault.wb_pc :
              fault.inst_misaligned ? fault.inst_misaligned_epc : fault.exe_pc;
    exp_tval = wb_cls ? fault.ldst_badaddr :
               fault.inst_misaligned ? fault.exe_pc :
               if_cls ? fault.inst_badaddr :
               ill ? fault.inst : 32'd0;
end

////////////////////////////////////////////////////////////
// properties
////////////////////////////////////////////////////////////

a_taken: assert property (@(posedge clk) disable iff (rst) trap_taken == exp_valid)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("trap_taken differs from the fault class rule");
    end

a_cause: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> trap.cause == exp_cause && trap.epc == exp_epc && trap.tval == exp_tval)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("trap record cause, epc or tval is wrong");
    end

a_trap_jump: assert property (@(posedge clk) disable iff (rst)
        trap_taken |=> redirect_valid && redirect_pc == $past({mtvec_base[31:2], 2'b00}))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("no redirect to mtvec after a trap");
    end

a_ret_jump: assert property (@(posedge clk) disable iff (rst)
        mret && !trap_taken |=> redirect_valid && redirect_pc == $past(mepc_q))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("no redirect to mepc after mret");
    end

a_one_shot: assert property (@(posedge clk) disable iff (rst)
        !trap_taken && !mret |=> !redirect_valid)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("redirect_valid without a request");
    end

a_apb_resp: assert property (@(posedge clk) disable iff (rst)
        apb.psel && apb.penable |-> pready && pslverr == !(apb.paddr inside
        {`CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MSCRATCH}))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("apb pready or pslverr is wrong");
    end

endmodule

`default_nettype wire

// ==== tests/trap_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "trap_config.svh"

module trap_tb
    import trap_pkg::*;
;

localparam int N_SCEN = 54;  // three rounds over the 18 fault kinds.
localparam int CAUSE_TAB [18] = '{0, 1, 12, 2, 3, 8, 9, 11, 0, 2, 2, 2, 4, 5, 6, 7, 13, 15};

logic                    clk;
logic                    rst;
fault_req_t              fault;
logic                    mret;
apb_req_t                apb;
logic [`XLEN-1:0]        prdata;
logic                    pready;
logic                    pslverr;
logic                    trap_taken;
logic                    redirect_valid;
logic [`IM_ADDR_LEN-1:0] redirect_pc;

logic [31:0]      lcg_state;
fault_req_t       f;
int               i;
int               kind;
logic             iv;
logic             hit;
logic [`XLEN-1:0] exp_cause;
logic [`XLEN-1:0] exp_epc;
logic [`XLEN-1:0] exp_tval;
logic [`XLEN-1:0] rd_data;
logic             rd_err;

trap_clk_gen u_clk (.clk(clk));

trap_top dut (.*);

bind trap_top trap_props u_props (.*);

////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
        abort_run($sformatf("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp));
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    apb.penable <= 1'b1;
    @(posedge clk);
    apb <= '0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
    @(posedge clk);
    apb.penable <= 1'b1;
    @(negedge clk);  // access cycle.
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    apb <= '0;
endtask

task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check(name, data, exp);
    check({name, " pslverr"}, 32'(err), 32'd0);
endtask

// one fault flag of the given kind with addresses taken from r.
function automatic fault_req_t make_fault(input int k, input logic v, input logic [31:0] r);
    fault_req_t x;
    x = '0;
    x.inst_valid          = v;
    x.inst                = r ^ 32'h0000_0073;
    x.exe_pc              = {r[31:2], 2'b00};
    x.wb_pc               = x.exe_pc - 32'd8;
    x.ldst_badaddr        = {r[15:0], r[31:16]};
    x.inst_badaddr        = x.exe_pc + 32'd4;
    x.inst_misaligned_epc = x.exe_pc + 32'd2;
    x.prv_cur             = PRV_M;
    x.prv_req             = PRV_U;
    case (k)
        0:  x.inst_misaligned = 1'b1;
        1:  x.inst_xes_fault = 1'b1;
        2:  x.inst_pg_fault = 1'b1;
        3:  x.ill_inst = 1'b1;
        4:  x.ebreak = 1'b1;
        5, 6, 7, 8: begin
            x.ecall   = 1'b1;
            x.prv_cur = (k == 5) ? PRV_U : (k == 6) ? PRV_S : (k == 7) ? PRV_M : PRV_H;
        end
        9: begin
            x.satp_upd = 1'b1;
            x.tvm      = 1'b1;
            x.prv_cur  = PRV_S;
        end
        10: begin
            x.sret    = 1'b1;
            x.tsr     = 1'b1;
            x.prv_cur = PRV_U;
        end
        11: begin
            x.prv_cur = PRV_U;
            x.prv_req = PRV_M;
        end
        12: x.load_misaligned = 1'b1;
        13: x.load_xes_fault = 1'b1;
        14: x.store_misaligned = 1'b1;
        15: x.store_xes_fault = 1'b1;
        16: x.load_pg_fault = 1'b1;
        17: x.store_pg_fault = 1'b1;
        default: ;
    endcase
    return x;
endfunction

////////////////////////////////////////////////////////////
// watchdog and assertion monitor
////////////////////////////////////////////////////////////

initial begin
    repeat (N_SCEN * 20 + 400) @(posedge clk);
    abort_run("watchdog timeout, the run did not finish");
end

always @(negedge clk) begin
    if (dut.u_props.fail_cnt != 0)
        abort_run("a trap_props assertion failed");
end

////////////////////////////////////////////////////////////
// stimulus
////////////////////////////////////////////////////////////

initial begin
    rst       = 1'b1;
    fault     = '0;
    mret      = 1'b0;
    apb       = '0;
    lcg_state = 32'he26a_6095;
    exp_cause = '0;
    exp_epc   = '0;
    exp_tval  = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("redirect_valid", 32'(redirect_valid), 32'd0);
    check("trap_taken", 32'(trap_taken), 32'd0);
    check("pslverr", 32'(pslverr), 32'd0);
    for (i = 0; i < 5; i++)
        read_check(8'(i * 4), 32'd0, $sformatf("prdata @%02h", i * 4));

    apb_write(`CSR_MTVEC, 32'h8000_0103);
    read_check(`CSR_MTVEC, 32'h8000_0103, "mtvec");
    apb_write(`CSR_MSCRATCH, 32'h1234_abcd);
    read_check(`CSR_MSCRATCH, 32'h1234_abcd, "mscratch");
    apb_read(8'h14, rd_data, rd_err);
    check("prdata unmapped", rd_data, 32'd0);
    check("pslverr unmapped", 32'(rd_err), 32'd1);

    for (i = 0; i < N_SCEN; i++) begin
        lcg_state = lcg_next(lcg_state);
        kind = i % 18;
        iv   = (i < 18) ? 1'b1 : (i < 36) ? 1'b0 : lcg_state[3];
        f    = make_fault(kind, iv, lcg_state);
        if (i >= 36 && kind >= 12)
            f.inst_pg_fault = 1'b1;  // fetch fault under a writeback fault.
        hit = (kind >= 12) || iv;
        @(posedge clk);
        fault <= f;
        @(negedge clk);
        check("trap_taken", 32'(trap_taken), 32'(hit));
        @(posedge clk);
        fault <= '0;
        @(negedge clk);
        check("redirect_valid", 32'(redirect_valid), 32'(hit));
        if (hit) begin
            check("redirect_pc", redirect_pc, 32'h8000_0100);
            exp_cause = CAUSE_TAB[kind];
            exp_epc   = (kind >= 12) ? f.wb_pc : (kind == 0) ? f.inst_misaligned_epc : f.exe_pc;
            exp_tval  = (kind >= 12) ? f.ldst_badaddr :
                        (kind == 0) ? f.exe_pc :
                        (kind < 3) ? f.inst_badaddr :
                        (exp_cause == 32'd2) ? f.inst : 32'd0;
        end
        read_check(`CSR_MCAUSE, exp_cause, "mcause");
        read_check(`CSR_MEPC, exp_epc, "mepc");
        read_check(`CSR_MTVAL, exp_tval, "mtval");
    end

    // return path.
    apb_write(`CSR_MEPC, 32'h0000_4567);
    read_check(`CSR_MEPC, 32'h0000_4566, "mepc");
    @(posedge clk);
    mret <= 1'b1;
    @(posedge clk);
    mret <= 1'b0;
    @(negedge clk);
    check("redirect_valid", 32'(redirect_valid), 32'd1);
    check("redirect_pc", redirect_pc, 32'h0000_4566);
    @(negedge clk);
    check("redirect_valid", 32'(redirect_valid), 32'd0);

    // mcause write collides with a load access fault.
    @(posedge clk);
    apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: `CSR_MCAUSE,
             pwdata: 32'hdead_beef};
    @(posedge clk);
    apb.penable <= 1'b1;
    fault       <= make_fault(13, 1'b1, lcg_state);
    @(posedge clk);
    apb   <= '0;
    fault <= '0;
    read_check(`CSR_MCAUSE, 32'd5, "mcause");

    @(negedge clk);
    if (dut.u_props.fail_cnt == 0) begin
        $display("Test passed");
        $finish;
    end else begin
        abort_run("a trap_props assertion failed");
    end
end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/trap_pkg.sv
tpu/tpu.sv
trap_csr/trap_csr.sv
verilog/trap_redirect.sv
verilog/trap_top.sv
tests/trap_clk_gen.sv
tests/trap_props.sv
tests/trap_tb.sv

// ==== Makefile ====
TOP = trap_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Icommon -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Icommon -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
